// File: run_sim.sh
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module controlUnit_tb -o controlUnit_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/controlUnit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: source/controlEncoder.sv
`timescale 1ns/100ps

module controlEncoder
(
	input logic CLK,
	input logic reset,
	input cuPkg::cuState_e state,
	input cuPkg::decodedInstr_t decoded,
	output cuPkg::controlWord_t controls
);

	cuPkg::controlWord_t word;

	always_comb
	begin
		word = '0;
		case (state)
			cuPkg::resetClear:
			begin
				word.clearRegs = 1'b1;
			end
			cuPkg::fetchAddr:
			begin
				// pc to mar
				word.marLoad = 1'b1;
				word.memRead = 1'b1;
				word.muxA = 2'd2;
				word.muxD = 1'b1;
				word.aluOp = 5'd16;
			end
			cuPkg::fetchIncPc:
			begin
				word.regFileLoad = 1'b1;
				word.memRead = 1'b1;
				word.memEnable = 1'b1;
				word.dataType = 2'd2;
				word.muxA = 2'd2;
				word.muxC = 3'd3;
				word.muxD = 1'b1;
				word.aluOp = 5'd17;
			end
			cuPkg::fetchWait:
			begin
				word.irLoad = 1'b1;
				word.memRead = 1'b1;
				word.memEnable = 1'b1;
				word.dataType = 2'd2;
			end
			cuPkg::dpImmAlu:
			begin
				word.regFileLoad = 1'b1;
				word.muxB = 2'd1;
				word.muxC = 3'd4;
				word.muxF = 2'd3;
				word.muxD = 1'b1;
				word.shiftType = 3'd1;
				word.aluEnable = 1'b1;
				word.aluOp = 5'd19;
			end
			cuPkg::dpImmWrite:
			begin
				word.regFileLoad = 1'b1;
				word.muxI = 2'd2;
				word.muxJ = 2'd1;
				word.shiftType = 3'd4;
				word.flagLoad = decoded.setFlags;
			end
			cuPkg::dpShift:
			begin
				// shift amount comes straight from the instruction
				word.regFileLoad = 1'b1;
				word.muxB = 2'd1;
				word.muxH = 1'b1;
				word.muxI = 2'd1;
				word.shiftAmount = decoded.shiftAmount;
				word.flagLoad = decoded.setFlags;
			end
			cuPkg::branchLink:
			begin
				word.regFileLoad = 1'b1;
				word.muxA = 2'd3;
				word.muxC = 3'd2;
				word.muxD = 1'b1;
				word.muxJ = 2'd1;
				word.shiftAmount = 5'd4;
				word.aluOp = 5'd16;
			end
			cuPkg::branchTarget:
			begin
				word.regFileLoad = 1'b1;
				word.muxB = 2'd1;
				word.flagLoad = 1'b1;
				word.muxC = 3'd4;
				word.muxD = 1'b1;
				word.muxF = 2'd3;
				word.muxI = 2'd2;
				word.muxJ = 2'd2;
				word.aluEnable = 1'b1;
				word.shiftType = 3'd4;
				word.aluOp = 5'd19;
			end
			cuPkg::branchWrite:
			begin
				// offset times four added to pc
				word.regFileLoad = 1'b1;
				word.muxA = 2'd2;
				word.muxC = 3'd3;
				word.muxB = 2'd1;
				word.muxD = 1'b1;
				word.muxI = 2'd2;
				word.shiftType = 3'd5;
				word.muxJ = 2'd1;
				word.shiftAmount = 5'd4;
				word.aluOp = 5'd4;
			end
			default:
			begin
				// decode drives nothing
				word = '0;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			controls <= '0;
		else
			controls <= word;
	end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/100ps

module controlUnit
(
	input logic CLK,
	input logic reset,
	input cuPkg::instrWord_u ir,
	input logic cond,
	input logic moc,
	output cuPkg::controlWord_t controls
);

	cuPkg::decodedInstr_t decoded;
	cuPkg::cuState_e state;

	instrDecoder decoder
	(
		.ir(ir),
		.decoded(decoded)
	);

	stateSequencer sequencer
	(
		.CLK(CLK),
		.reset(reset),
		.cond(cond),
		.moc(moc),
		.decoded(decoded),
		.state(state)
	);

	// registered one cycle behind the state
	controlEncoder encoder
	(
		.CLK(CLK),
		.reset(reset),
		.state(state),
		.decoded(decoded),
		.controls(controls)
	);

endmodule

// File: source/cuPkg.sv
`include "cu_config.svh"

package cuPkg;

	// data-processing view of the instruction word
	typedef struct packed {
		logic [`CU_INSTR_WIDTH-`CU_LINK_BIT-`CU_CLASS_WIDTH-2:0] cond;
		logic [`CU_CLASS_WIDTH-1:0] instrClass;
		// operation flags in bits 24 to 21
		logic [`CU_LINK_BIT-`CU_SET_FLAGS_BIT-1:0] opFlags;
		logic setFlags;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [`CU_SHIFT_AMT_WIDTH-1:0] shiftAmount;
		logic [1:0] shiftKind;
		logic regShift;
		logic [3:0] rm;
	} dpView_t;

	// branch view with a signed word offset below the link bit
	typedef struct packed {
		logic [`CU_INSTR_WIDTH-`CU_LINK_BIT-`CU_CLASS_WIDTH-2:0] cond;
		logic [`CU_CLASS_WIDTH-1:0] instrClass;
		logic link;
		logic [`CU_LINK_BIT-1:0] offset;
	} branchView_t;

	typedef union packed {
		dpView_t dpView;
		branchView_t branchView;
	} instrWord_u;

	typedef enum logic [1:0] {
		dataProcImm,
		dataProcShift,
		branch,
		unsupported
	} instrClass_e;

	typedef struct packed {
		instrClass_e instrClass;
		logic setFlags;
		logic link;
		logic [`CU_SHIFT_AMT_WIDTH-1:0] shiftAmount;
	} decodedInstr_t;

	typedef enum logic [3:0] {
		resetClear,
		fetchAddr,
		fetchIncPc,
		fetchWait,
		decode,
		dpImmAlu,
		dpImmWrite,
		dpShift,
		branchLink,
		branchTarget,
		branchWrite
	} cuState_e;

	typedef struct packed {
		logic regFileLoad;
		logic irLoad;
		logic marLoad;
		logic flagLoad;
		logic clearRegs;
		logic memRead;
		logic memEnable;
		logic [1:0] dataType;
		logic [1:0] muxA;
		logic [1:0] muxB;
		logic [2:0] muxC;
		logic muxD;
		logic [1:0] muxF;
		logic muxH;
		logic [1:0] muxI;
		logic [1:0] muxJ;
		logic aluEnable;
		logic [2:0] shiftType;
		logic [`CU_SHIFT_AMT_WIDTH-1:0] shiftAmount;
		logic [`CU_ALU_OP_WIDTH-1:0] aluOp;
	} controlWord_t;

endpackage

// File: source/cu_config.svh
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// instruction word
`define CU_INSTR_WIDTH 32

// opcode class field in bits 27 to 25
`define CU_CLASS_WIDTH 3
`define CU_CLASS_DP_SHIFT 3'b000
`define CU_CLASS_DP_IMM 3'b001
`define CU_CLASS_BRANCH 3'b101

// single-bit fields
`define CU_SET_FLAGS_BIT 20
`define CU_LINK_BIT 24

// control field widths
`define CU_SHIFT_AMT_WIDTH 5
`define CU_ALU_OP_WIDTH 5

`endif

// File: source/instrDecoder.sv
`timescale 1ns/100ps
`include "cu_config.svh"

module instrDecoder
(
	input cuPkg::instrWord_u ir,
	output cuPkg::decodedInstr_t decoded
);

	always_comb
	begin
		// class field sits at the same place in both views
		case (ir.dpView.instrClass)
			`CU_CLASS_DP_IMM:
			begin
				decoded.instrClass = cuPkg::dataProcImm;
			end
			`CU_CLASS_DP_SHIFT:
			begin
				decoded.instrClass = cuPkg::dataProcShift;
			end
			`CU_CLASS_BRANCH:
			begin
				decoded.instrClass = cuPkg::branch;
			end
			default:
			begin
				// load/store and the rest are not handled here
				decoded.instrClass = cuPkg::unsupported;
			end
		endcase

		decoded.setFlags = ir.dpView.setFlags;
		decoded.shiftAmount = ir.dpView.shiftAmount;

		// link only matters for branches
		decoded.link = ir.branchView.link;
	end

endmodule

// File: source/stateSequencer.sv
`timescale 1ns/100ps

module stateSequencer
(
	input logic CLK,
	input logic reset,
	input logic cond,
	input logic moc,
	input cuPkg::decodedInstr_t decoded,
	output cuPkg::cuState_e state
);

	cuPkg::cuState_e nextState;

	always_ff @(posedge CLK)
	begin
		if (reset)
			state <= cuPkg::resetClear;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			cuPkg::resetClear:
				nextState = cuPkg::fetchAddr;
			cuPkg::fetchAddr:
				nextState = cuPkg::fetchIncPc;
			cuPkg::fetchIncPc:
				nextState = cuPkg::fetchWait;
			cuPkg::fetchWait:
			begin
				// hold until memory reports completion
				if (moc)
					nextState = cuPkg::decode;
			end
			cuPkg::decode:
			begin
				if (!cond)
				begin
					nextState = cuPkg::fetchAddr;
				end
				else
				begin
					case (decoded.instrClass)
						cuPkg::dataProcImm:
							nextState = cuPkg::dpImmAlu;
						cuPkg::dataProcShift:
							nextState = cuPkg::dpShift;
						cuPkg::branch:
						begin
							if (decoded.link)
								nextState = cuPkg::branchLink;
							else
								nextState = cuPkg::branchTarget;
						end
						default:
							nextState = cuPkg::fetchAddr;
					endcase
				end
			end
			cuPkg::dpImmAlu:
				nextState = cuPkg::dpImmWrite;
			cuPkg::branchLink:
				nextState = cuPkg::branchTarget;
			cuPkg::branchTarget:
				nextState = cuPkg::branchWrite;
			// last step of every execute path
			cuPkg::dpImmWrite,
			cuPkg::dpShift,
			cuPkg::branchWrite:
				nextState = cuPkg::fetchAddr;
			default:
				nextState = cuPkg::resetClear;
		endcase
	end

endmodule

// File: tb/controlUnit_properties.sv
`timescale 1ns/100ps

module controlUnit_properties
(
	input logic CLK,
	input logic reset,
	input logic moc,
	input cuPkg::cuState_e state
);

	resetToClear: assert property (@(posedge CLK)
		reset |=> (state == cuPkg::resetClear))
		else $error("state is not resetClear one edge after reset");

	// waiting for memory holds until moc
	holdWithoutMoc: assert property (@(posedge CLK) disable iff (reset)
		(state == cuPkg::fetchWait && !moc) |=> (state == cuPkg::fetchWait))
		else $error("fetchWait left while moc was low");

	decodeAfterWait: assert property (@(posedge CLK) disable iff (reset)
		(state == cuPkg::fetchWait && moc) |=> (state == cuPkg::decode))
		else $error("decode did not follow fetchWait");

endmodule

bind stateSequencer controlUnit_properties props
(
	.CLK(CLK),
	.reset(reset),
	.moc(moc),
	.state(state)
);

// File: tb/controlUnit_tb.sv
`timescale 1ns/100ps

module controlUnit_tb;

	localparam int NUM_INSTRUCTIONS = 300;
	localparam int MAX_INSTR_CYCLES = 13;
	// worst case per instruction plus reset and slack
	localparam int TIMEOUT_CYCLES = NUM_INSTRUCTIONS * MAX_INSTR_CYCLES + 600;
	localparam int RESET_CYCLES = 4;
	localparam logic [31:0] SEED = 32'd66353;

	// reference microprogram states
	typedef enum int {
		refReset,
		refFetchAddr,
		refFetchIncPc,
		refFetchWait,
		refDecode,
		refDpImmAlu,
		refDpImmWrite,
		refDpShift,
		refBranchLink,
		refBranchTarget,
		refBranchWrite
	} modelState_e;

	logic CLK;
	logic reset;
	cuPkg::instrWord_u ir;
	logic cond;
	logic moc;
	cuPkg::controlWord_t controls;

	cuPkg::controlWord_t expected;
	modelState_e modelState;
	modelState_e shownState;
	logic [31:0] rngState;
	logic inReset;
	logic waitActive;
	logic [1:0] waitLeft;
	logic allDone;
	int cycleCount;
	int watchCycles;
	int errorCount;
	int testStartErrors;
	int failedTests;
	int testIndex;
	string testName;

	controlUnit UUT
	(
		.CLK(CLK),
		.reset(reset),
		.ir(ir),
		.cond(cond),
		.moc(moc),
		.controls(controls)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#4 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// control word for the state held during the cycle that just ended
	function automatic cuPkg::controlWord_t expectedWord(input modelState_e s,
		input logic [31:0] instr);
		cuPkg::controlWord_t w;
		w = '0;
		case (s)
			refReset:
				w = '{clearRegs: 1'b1, default: '0};
			refFetchAddr:
				w = '{marLoad: 1'b1, memRead: 1'b1, muxA: 2'd2, muxD: 1'b1, aluOp: 5'd16,
					default: '0};
			refFetchIncPc:
				w = '{regFileLoad: 1'b1, memRead: 1'b1, memEnable: 1'b1, dataType: 2'd2,
					muxA: 2'd2, muxC: 3'd3, muxD: 1'b1, aluOp: 5'd17, default: '0};
			refFetchWait:
				w = '{irLoad: 1'b1, memRead: 1'b1, memEnable: 1'b1, dataType: 2'd2,
					default: '0};
			refDpImmAlu:
				w = '{regFileLoad: 1'b1, muxB: 2'd1, muxC: 3'd4, muxF: 2'd3, muxD: 1'b1,
					shiftType: 3'd1, aluEnable: 1'b1, aluOp: 5'd19, default: '0};
			refDpImmWrite:
				w = '{regFileLoad: 1'b1, muxI: 2'd2, muxJ: 2'd1, shiftType: 3'd4,
					flagLoad: instr[20], default: '0};
			refDpShift:
				w = '{regFileLoad: 1'b1, muxB: 2'd1, muxH: 1'b1, muxI: 2'd1,
					shiftAmount: instr[11:7], flagLoad: instr[20], default: '0};
			refBranchLink:
				w = '{regFileLoad: 1'b1, muxA: 2'd3, muxC: 3'd2, muxD: 1'b1, muxJ: 2'd1,
					shiftAmount: 5'd4, aluOp: 5'd16, default: '0};
			refBranchTarget:
				w = '{regFileLoad: 1'b1, muxB: 2'd1, flagLoad: 1'b1, muxC: 3'd4, muxD: 1'b1,
					muxF: 2'd3, muxI: 2'd2, muxJ: 2'd2, aluEnable: 1'b1, shiftType: 3'd4,
					aluOp: 5'd19, default: '0};
			refBranchWrite:
				w = '{regFileLoad: 1'b1, muxA: 2'd2, muxC: 3'd3, muxB: 2'd1, muxD: 1'b1,
					muxI: 2'd2, shiftType: 3'd5, muxJ: 2'd1, shiftAmount: 5'd4, aluOp: 5'd4,
					default: '0};
			default:
				w = '0;
		endcase
		return w;
	endfunction

	function automatic modelState_e nextModelState(input modelState_e s,
		input logic [31:0] instr, input logic condIn, input logic mocIn);
		modelState_e n;
		n = refReset;
		case (s)
			refReset:
				n = refFetchAddr;
			refFetchAddr:
				n = refFetchIncPc;
			refFetchIncPc:
				n = refFetchWait;
			refFetchWait:
				n = mocIn ? refDecode : refFetchWait;
			refDecode:
			begin
				// class field in bits 27 to 25 and link in bit 24
				if (!condIn)
					n = refFetchAddr;
				else if (instr[27:25] == 3'b001)
					n = refDpImmAlu;
				else if (instr[27:25] == 3'b000)
					n = refDpShift;
				else if (instr[27:25] == 3'b101)
					n = instr[24] ? refBranchLink : refBranchTarget;
				else
					n = refFetchAddr;
			end
			refDpImmAlu:
				n = refDpImmWrite;
			refBranchLink:
				n = refBranchTarget;
			refBranchTarget:
				n = refBranchWrite;
			default:
				n = refFetchAddr;
		endcase
		return n;
	endfunction

	task automatic newInstruction();
		logic [31:0] word;
		logic [2:0] cls;
		string kind;
		rngState = xorshift(rngState);
		word = rngState;
		rngState = xorshift(rngState);
		case (rngState[2:0])
			3'd0, 3'd1:
			begin
				cls = 3'b001;
				kind = "dp immediate";
			end
			3'd2, 3'd3:
			begin
				cls = 3'b000;
				kind = "dp shifted register";
			end
			3'd4, 3'd5, 3'd6:
			begin
				cls = 3'b101;
				kind = word[24] ? "branch with link" : "branch";
			end
			default:
			begin
				cls = rngState[10:8];
				// moves any kept code onto an unsupported one
				if (cls == 3'b000 || cls == 3'b001 || cls == 3'b101)
					cls = cls ^ 3'b010;
				kind = "unsupported class";
			end
		endcase
		word[27:25] = cls;
		ir = word;
		rngState = xorshift(rngState);
		cond = (rngState[2:0] != 3'd0);
		testName = $sformatf("%s cond=%0d ir=%h", kind, cond, word);
	endtask

	// memory completes 0 to 3 cycles after the fetch wait word shows up
	task automatic driveMemoryCompletion();
		if (moc)
		begin
			moc = 1'b0;
			waitActive = 1'b0;
		end
		else
		begin
			if (!waitActive && controls.irLoad)
			begin
				rngState = xorshift(rngState);
				waitActive = 1'b1;
				waitLeft = rngState[1:0];
			end
			if (waitActive)
			begin
				if (waitLeft == 2'd0)
					moc = 1'b1;
				else
					waitLeft = waitLeft - 2'd1;
			end
		end
	endtask

	task automatic reportTest();
		if (errorCount == testStartErrors)
		begin
			$display("test %0d %s: passed", testIndex, testName);
		end
		else
		begin
			failedTests++;
			$display("test %0d %s: failed", testIndex, testName);
		end
		testStartErrors = errorCount;
	endtask

	always @(posedge CLK)
	begin
		watchCycles++;
		if (watchCycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		reset = 1'b1;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		rngState = SEED;
		modelState = refReset;
		waitActive = 1'b0;
		waitLeft = 2'd0;
		allDone = 1'b0;
		cycleCount = 0;
		watchCycles = 0;
		errorCount = 0;
		testStartErrors = 0;
		failedTests = 0;
		testIndex = 0;
		testName = "reset";
		while (!allDone)
		begin
			@(posedge CLK);
			inReset = reset;
			shownState = modelState;
			if (inReset)
			begin
				expected = '0;
				modelState = refReset;
			end
			else
			begin
				expected = expectedWord(modelState, ir);
				modelState = nextModelState(modelState, ir, cond, moc);
			end
			#1;
			cycleCount++;
			if (controls !== expected)
			begin
				errorCount++;
				$display("Error: controls expected %h actual %h at cycle %0d", expected,
					controls, cycleCount);
			end
			if (cycleCount == RESET_CYCLES)
				reset = 1'b0;
			// fetchAddr word on the outputs closes one instruction
			if (!inReset && shownState == refFetchAddr)
			begin
				reportTest();
				if (testIndex == NUM_INSTRUCTIONS)
				begin
					allDone = 1'b1;
				end
				else
				begin
					testIndex++;
					newInstruction();
				end
			end
			driveMemoryCompletion();
		end
		$display("tests %0d, failed %0d, errors %0d", testIndex + 1, failedTests, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/cuPkg.sv
source/instrDecoder.sv
source/stateSequencer.sv
source/controlEncoder.sv
source/controlUnit.sv
tb/controlUnit_properties.sv
tb/controlUnit_tb.sv
